// File: Bender.yml
package:
  name: kitchen_action

sources:
  - verilog/kitchen_pkg.sv
  - verilog/frame_timer.sv
  - verilog/player_locator.sv
  - verilog/hand_action.sv
  - verilog/chop_board.sv
  - verilog/pot_cooker.sv
  - verilog/object_grid.sv
  - verilog/kitchen_action.sv
  - target: test
    include_dirs:
      - tests
    files:
      - tests/tb_kitchen_action.sv

// File: kitchen_action.f
+incdir+tests
verilog/kitchen_pkg.sv
verilog/frame_timer.sv
verilog/player_locator.sv
verilog/hand_action.sv
verilog/chop_board.sv
verilog/pot_cooker.sv
verilog/object_grid.sv
verilog/kitchen_action.sv
tests/tb_kitchen_action.sv

// File: tests/kitchen_cases.svh
// name, play, player row and col, dir, player_state, hold cycles,
// expected tile row and col, expected object, expected chop_left and cook_left (-1 skips)
task automatic fill_cases();
    add_case("reset crate a", 1, 4, 5, kitchen_pkg::DOWN, kitchen_pkg::P_NOTHING, 1,
             2, 0, kitchen_pkg::G_ONION_WHOLE, kitchen_pkg::CHOP_FRAMES,
             kitchen_pkg::COOK_FRAMES);
    add_case("reset crate b", 1, 4, 5, kitchen_pkg::DOWN, kitchen_pkg::P_NOTHING, 1,
             3, 0, kitchen_pkg::G_ONION_WHOLE, -1, -1);
    add_case("reset bowl", 1, 4, 5, kitchen_pkg::DOWN, kitchen_pkg::P_NOTHING, 1,
             6, 12, kitchen_pkg::G_BOWL_EMPTY, -1, -1);
    add_case("reset pot", 1, 4, 5, kitchen_pkg::DOWN, kitchen_pkg::P_NOTHING, 1,
             0, 8, kitchen_pkg::G_POT_EMPTY, -1, -1);
    add_case("reset extinguisher", 1, 4, 5, kitchen_pkg::DOWN, kitchen_pkg::P_NOTHING, 1,
             6, 0, kitchen_pkg::G_EXTINGUISHER, -1, -1);
    add_case("reset board empty", 1, 4, 5, kitchen_pkg::DOWN, kitchen_pkg::P_NOTHING, 1,
             7, 2, kitchen_pkg::G_EMPTY, -1, -1);
    add_case("reset floor empty", 1, 4, 5, kitchen_pkg::DOWN, kitchen_pkg::P_NOTHING, 1,
             4, 6, kitchen_pkg::G_EMPTY, -1, -1);
    add_case("pick crate onion", 1, 2, 1, kitchen_pkg::LEFT, kitchen_pkg::P_ONION_WHOLE, 2,
             2, 0, kitchen_pkg::G_ONION_WHOLE, -1, -1);
    add_case("onion on board", 1, 6, 2, kitchen_pkg::DOWN, kitchen_pkg::P_NOTHING, 2,
             7, 2, kitchen_pkg::G_ONION_WHOLE, -1, -1);
    add_case("chop onion", 1, 6, 2, kitchen_pkg::DOWN, kitchen_pkg::P_CHOPPING,
             kitchen_pkg::CHOP_FRAMES + 4, 7, 2, kitchen_pkg::G_ONION_CHOPPED,
             kitchen_pkg::CHOP_FRAMES, -1);
    add_case("stop chopping", 1, 6, 2, kitchen_pkg::DOWN, kitchen_pkg::P_NOTHING, 1,
             7, 2, kitchen_pkg::G_ONION_CHOPPED, -1, -1);
    add_case("pick chopped onion", 1, 6, 2, kitchen_pkg::DOWN, kitchen_pkg::P_ONION_CHOPPED, 2,
             7, 2, kitchen_pkg::G_EMPTY, -1, -1);
    add_case("onion into pot", 1, 1, 8, kitchen_pkg::UP, kitchen_pkg::P_NOTHING, 2,
             0, 8, kitchen_pkg::G_POT_RAW, -1, -1);
    add_case("pot cooked", 1, 1, 8, kitchen_pkg::UP, kitchen_pkg::P_NOTHING,
             kitchen_pkg::COOK_FRAMES + 5, 0, 8, kitchen_pkg::G_POT_COOKED, -1,
             kitchen_pkg::COOK_FRAMES);
    add_case("pot on fire", 1, 1, 8, kitchen_pkg::UP, kitchen_pkg::P_NOTHING,
             kitchen_pkg::BURN_FRAMES + 5, 0, 8, kitchen_pkg::G_FIRE, -1, -1);
    add_case("pick extinguisher", 1, 5, 0, kitchen_pkg::DOWN, kitchen_pkg::P_EXT_OFF, 2,
             6, 0, kitchen_pkg::G_EMPTY, -1, -1);
    add_case("put out fire", 1, 1, 8, kitchen_pkg::UP, kitchen_pkg::P_EXT_ON, 2,
             0, 8, kitchen_pkg::G_POT_EMPTY, -1, -1);
    add_case("extinguisher off", 1, 4, 5, kitchen_pkg::DOWN, kitchen_pkg::P_EXT_OFF, 1,
             5, 5, kitchen_pkg::G_EMPTY, -1, -1);
    add_case("put down play low", 0, 4, 5, kitchen_pkg::DOWN, kitchen_pkg::P_NOTHING, 2,
             5, 5, kitchen_pkg::G_EMPTY, -1, -1);
    add_case("play back high", 1, 4, 5, kitchen_pkg::DOWN, kitchen_pkg::P_NOTHING, 2,
             5, 5, kitchen_pkg::G_EMPTY, -1, -1);
    add_case("take extinguisher", 1, 4, 5, kitchen_pkg::DOWN, kitchen_pkg::P_EXT_OFF, 1,
             5, 5, kitchen_pkg::G_EMPTY, -1, -1);
    add_case("put down play high", 1, 4, 5, kitchen_pkg::DOWN, kitchen_pkg::P_NOTHING, 2,
             5, 5, kitchen_pkg::G_EXTINGUISHER, -1, -1);
endtask

// File: tests/tb_kitchen_action.sv
`timescale 1ns/1ns
`default_nettype none

module tb_kitchen_action;

    logic                            vsync;
    logic                            reset;
    logic                            play;
    logic [kitchen_pkg::PIXEL_W-1:0] player_x;
    logic [kitchen_pkg::PIXEL_W-1:0] player_y;
    kitchen_pkg::dir_e               dir;
    kitchen_pkg::player_state_e      player_state;
    kitchen_pkg::grid_t              grid;
    logic [kitchen_pkg::TIMER_W-1:0] chop_left;
    logic [kitchen_pkg::TIMER_W-1:0] cook_left;

    // stimulus table with one entry per queue index
    string                      case_name[$];
    bit                         case_play[$];
    int                         case_row[$];
    int                         case_col[$];
    kitchen_pkg::dir_e          case_dir[$];
    kitchen_pkg::player_state_e case_state[$];
    int                         case_hold[$];
    int                         case_exp_row[$];
    int                         case_exp_col[$];
    kitchen_pkg::grid_obj_e     case_exp_obj[$];
    int                         case_exp_chop[$];
    int                         case_exp_cook[$];

    int error_count = 0;
    int fail_count = 0;
    int cycle_count = 0;
    int cycle_limit = 0;

    kitchen_action i_dut (
        .vsync(vsync), .reset(reset), .play(play),
        .player_x(player_x), .player_y(player_y), .dir(dir), .player_state(player_state),
        .grid(grid), .chop_left(chop_left), .cook_left(cook_left)
    );

    initial begin
        vsync = 1'b0;
        forever #4 vsync = ~vsync;
    end

    always @(posedge vsync) begin
        cycle_count = cycle_count + 1;
        if ((cycle_limit > 0) && (cycle_count > cycle_limit)) begin
            $display("run timed out after %0d cycles", cycle_count);
            $display("tests failed");
            $finish;
        end
    end

    task automatic add_case(input string name, input bit p, input int r, input int c,
                            input kitchen_pkg::dir_e d, input kitchen_pkg::player_state_e s,
                            input int hold, input int exp_r, input int exp_c,
                            input kitchen_pkg::grid_obj_e exp_obj, input int exp_chop,
                            input int exp_cook);
        case_name.push_back(name);
        case_play.push_back(p);
        case_row.push_back(r);
        case_col.push_back(c);
        case_dir.push_back(d);
        case_state.push_back(s);
        case_hold.push_back(hold);
        case_exp_row.push_back(exp_r);
        case_exp_col.push_back(exp_c);
        case_exp_obj.push_back(exp_obj);
        case_exp_chop.push_back(exp_chop);
        case_exp_cook.push_back(exp_cook);
    endtask

    `include "kitchen_cases.svh"

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            error_count++;
            $display("Error at %0t ns: %s is %0d, expected %0d", $time, name, actual, expected);
        end
    endtask

    initial begin
        int errors_before;
        int total_hold;
        reset = 1'b1;
        play = 1'b0;
        player_x = '0;
        player_y = '0;
        dir = kitchen_pkg::LEFT;
        player_state = kitchen_pkg::P_NOTHING;
        fill_cases();
        total_hold = 0;
        for (int i = 0; i < case_hold.size(); i++) begin
            total_hold += case_hold[i];
        end
        cycle_limit = total_hold + 10 + 50; // reset cycles plus margin
        repeat (10) @(posedge vsync);
        reset <= 1'b0;
        for (int i = 0; i < case_name.size(); i++) begin
            @(posedge vsync);
            play <= case_play[i];
            player_x <= kitchen_pkg::PIXEL_W'(case_col[i] * kitchen_pkg::TILE_SIZE);
            player_y <= kitchen_pkg::PIXEL_W'(case_row[i] * kitchen_pkg::TILE_SIZE);
            dir <= case_dir[i];
            player_state <= case_state[i];
            repeat (case_hold[i]) @(posedge vsync);
            @(negedge vsync); // grid settled
            errors_before = error_count;
            check_value($sformatf("grid[%0d][%0d]", case_exp_row[i], case_exp_col[i]),
                        grid[case_exp_row[i]][case_exp_col[i]], case_exp_obj[i]);
            if (case_exp_chop[i] >= 0) begin
                check_value("chop_left", chop_left, case_exp_chop[i]);
            end
            if (case_exp_cook[i] >= 0) begin
                check_value("cook_left", cook_left, case_exp_cook[i]);
            end
            if (error_count == errors_before) begin
                $display("test %0d %s: ok", i, case_name[i]);
            end else begin
                fail_count++;
                $display("test %0d %s: FAIL", i, case_name[i]);
            end
        end
        $display("%0d tests run, %0d passed, %0d failed, %0d errors", case_name.size(),
                 case_name.size() - fail_count, fail_count, error_count);
        if (error_count == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog/chop_board.sv
`timescale 1ns/1ns
`default_nettype none

module chop_board (
    input  wire logic                          vsync,
    input  wire logic                          reset,
    input  wire logic                          play,
    input  wire kitchen_pkg::player_state_e    player_state,
    input  wire logic [kitchen_pkg::ROW_W-1:0] front_row,
    input  wire logic [kitchen_pkg::COL_W-1:0] front_col,
    input  wire logic                          front_valid,
    input  wire kitchen_pkg::grid_t            grid,
    output logic                               board_we,
    output kitchen_pkg::grid_obj_e             board_obj,
    output logic [kitchen_pkg::TIMER_W-1:0]    chop_left
);

    kitchen_pkg::player_state_e prev_state;
    logic                       chop_run;
    logic                       chop_restart;
    logic                       at_board;
    logic                       onion_on_board;
    logic                       start_chop;
    logic                       chop_done;

    frame_timer #(.length(kitchen_pkg::CHOP_FRAMES)) i_chop_timer (
        .vsync(vsync), .reset(reset), .run(chop_run), .restart(chop_restart),
        .time_left(chop_left)
    );

    assign at_board = front_valid && (front_row == kitchen_pkg::BOARD_ROW) &&
                      (front_col == kitchen_pkg::BOARD_COL);
    assign onion_on_board =
        (grid[kitchen_pkg::BOARD_ROW][kitchen_pkg::BOARD_COL] == kitchen_pkg::G_ONION_WHOLE);
    assign start_chop = (player_state == kitchen_pkg::P_CHOPPING) &&
                        (prev_state == kitchen_pkg::P_NOTHING) && at_board;
    assign chop_done = (player_state == kitchen_pkg::P_CHOPPING) && !start_chop && at_board &&
                       (chop_left == '0) && onion_on_board;

    assign board_we = play && chop_done;
    assign board_obj = kitchen_pkg::G_ONION_CHOPPED;

    always_ff @(posedge vsync) begin
        if (reset) begin
            prev_state <= kitchen_pkg::P_NOTHING;
            chop_run <= 1'b0;
            chop_restart <= 1'b1;
        end else begin
            prev_state <= player_state;
            if (!play) begin
                chop_run <= 1'b0;
            end else if (start_chop || chop_done) begin
                chop_run <= 1'b0; // fresh count for the next onion
                chop_restart <= 1'b1;
            end else if ((player_state == kitchen_pkg::P_CHOPPING) && at_board &&
                         onion_on_board) begin
                chop_run <= 1'b1;
                chop_restart <= 1'b0;
            end else begin
                chop_run <= 1'b0; // count is kept while away
            end
        end
    end

endmodule

`default_nettype wire

// File: verilog/frame_timer.sv
`timescale 1ns/1ns
`default_nettype none

module frame_timer #(
    parameter int length = 5
) (
    input  wire logic                          vsync,
    input  wire logic                          reset,
    input  wire logic                          run,
    input  wire logic                          restart,
    output logic [kitchen_pkg::TIMER_W-1:0]    time_left
);

    always_ff @(posedge vsync) begin
        if (reset || restart) begin
            time_left <= kitchen_pkg::TIMER_W'(length);
        end else if (run && (time_left != '0)) begin
            time_left <= time_left - 1'b1; // one frame gone
        end
    end

endmodule

`default_nettype wire

// File: verilog/hand_action.sv
`timescale 1ns/1ns
`default_nettype none

module hand_action (
    input  wire logic                          vsync,
    input  wire logic                          reset,
    input  wire logic                          play,
    input  wire kitchen_pkg::player_state_e    player_state,
    input  wire logic [kitchen_pkg::ROW_W-1:0] front_row,
    input  wire logic [kitchen_pkg::COL_W-1:0] front_col,
    input  wire logic                          front_valid,
    input  wire kitchen_pkg::grid_t            grid,
    output logic                               hand_we,
    output logic [kitchen_pkg::ROW_W-1:0]      hand_row,
    output logic [kitchen_pkg::COL_W-1:0]      hand_col,
    output kitchen_pkg::grid_obj_e             hand_obj
);

    kitchen_pkg::player_state_e prev_state;
    kitchen_pkg::grid_obj_e     front_obj;
    logic                       change_we;
    logic                       at_crate;
    logic                       at_bowl;

    always_ff @(posedge vsync) begin
        if (reset) begin
            prev_state <= kitchen_pkg::P_NOTHING;
        end else begin
            prev_state <= player_state;
        end
    end

    assign front_obj = grid[front_row][front_col];
    assign at_crate = (front_col == kitchen_pkg::CRATE_COL) &&
                      ((front_row == kitchen_pkg::CRATE_ROW_A) ||
                       (front_row == kitchen_pkg::CRATE_ROW_B));
    assign at_bowl = (front_row == kitchen_pkg::BOWL_ROW) && (front_col == kitchen_pkg::BOWL_COL);

    always_comb begin
        change_we = 1'b0;
        hand_obj = kitchen_pkg::G_EMPTY;
        if (player_state == kitchen_pkg::P_NOTHING) begin
            // put down
            change_we = 1'b1;
            case (prev_state)
                kitchen_pkg::P_ONION_WHOLE:   hand_obj = kitchen_pkg::G_ONION_WHOLE;
                kitchen_pkg::P_ONION_CHOPPED: begin
                    if (front_obj == kitchen_pkg::G_POT_EMPTY) begin
                        hand_obj = kitchen_pkg::G_POT_RAW;
                    end else if (front_obj == kitchen_pkg::G_EMPTY) begin
                        hand_obj = kitchen_pkg::G_ONION_CHOPPED;
                    end else begin
                        change_we = 1'b0;
                    end
                end
                kitchen_pkg::P_POT_EMPTY: begin
                    if (front_obj == kitchen_pkg::G_ONION_CHOPPED) begin
                        hand_obj = kitchen_pkg::G_POT_RAW;
                    end else if (front_obj == kitchen_pkg::G_EMPTY) begin
                        hand_obj = kitchen_pkg::G_POT_EMPTY;
                    end else begin
                        change_we = 1'b0;
                    end
                end
                kitchen_pkg::P_POT_RAW:    hand_obj = kitchen_pkg::G_POT_RAW;
                kitchen_pkg::P_POT_COOKED: hand_obj = kitchen_pkg::G_POT_COOKED;
                kitchen_pkg::P_BOWL_EMPTY: hand_obj = kitchen_pkg::G_BOWL_EMPTY;
                kitchen_pkg::P_BOWL_FULL:  hand_obj = kitchen_pkg::G_BOWL_FULL;
                kitchen_pkg::P_EXT_OFF:    hand_obj = kitchen_pkg::G_EXTINGUISHER;
                default:                   change_we = 1'b0; // was chopping or empty handed
            endcase
        end else if (player_state == kitchen_pkg::P_EXT_ON) begin
            change_we = (front_obj == kitchen_pkg::G_FIRE);
            hand_obj = kitchen_pkg::G_POT_EMPTY;
        end else if (prev_state == kitchen_pkg::P_NOTHING) begin
            // pick up where crates and the bowl stack never run out
            change_we = (player_state != kitchen_pkg::P_CHOPPING);
            if (at_crate && (player_state == kitchen_pkg::P_ONION_WHOLE)) begin
                hand_obj = kitchen_pkg::G_ONION_WHOLE;
            end else if (at_bowl && (player_state == kitchen_pkg::P_BOWL_EMPTY)) begin
                hand_obj = kitchen_pkg::G_BOWL_EMPTY;
            end
        end else if ((prev_state == kitchen_pkg::P_POT_COOKED) &&
                     (player_state == kitchen_pkg::P_POT_EMPTY)) begin
            change_we = 1'b1; // soup poured into the bowl
            hand_obj = kitchen_pkg::G_BOWL_FULL;
        end else if ((prev_state == kitchen_pkg::P_POT_EMPTY) &&
                     (player_state == kitchen_pkg::P_POT_RAW)) begin
            change_we = 1'b1; // onion scooped off the tile
        end else if ((prev_state == kitchen_pkg::P_BOWL_EMPTY) &&
                     (player_state == kitchen_pkg::P_BOWL_FULL)) begin
            change_we = 1'b1;
            hand_obj = kitchen_pkg::G_POT_EMPTY;
        end
    end

    assign hand_we = change_we && play && front_valid;
    assign hand_row = front_row;
    assign hand_col = front_col;

endmodule

`default_nettype wire

// File: verilog/kitchen_action.sv
`timescale 1ns/1ns
`default_nettype none

module kitchen_action (
    input  wire logic                            vsync,
    input  wire logic                            reset,
    input  wire logic                            play,
    input  wire logic [kitchen_pkg::PIXEL_W-1:0] player_x,
    input  wire logic [kitchen_pkg::PIXEL_W-1:0] player_y,
    input  wire kitchen_pkg::dir_e               dir,
    input  wire kitchen_pkg::player_state_e      player_state,
    output kitchen_pkg::grid_t                   grid,
    output logic [kitchen_pkg::TIMER_W-1:0]      chop_left,
    output logic [kitchen_pkg::TIMER_W-1:0]      cook_left
);

    logic [kitchen_pkg::ROW_W-1:0] front_row;
    logic [kitchen_pkg::COL_W-1:0] front_col;
    logic                          front_valid;
    logic                          hand_we;
    logic [kitchen_pkg::ROW_W-1:0] hand_row;
    logic [kitchen_pkg::COL_W-1:0] hand_col;
    kitchen_pkg::grid_obj_e        hand_obj;
    logic                          board_we;
    kitchen_pkg::grid_obj_e        board_obj;
    logic                          pot_we;
    kitchen_pkg::grid_obj_e        pot_obj;

    // own tile is only needed inside the locator
    player_locator i_locator (
        .player_x(player_x), .player_y(player_y), .dir(dir),
        .row(), .col(),
        .front_row(front_row), .front_col(front_col), .front_valid(front_valid)
    );

    object_grid i_grid (
        .vsync(vsync), .reset(reset),
        .hand_we(hand_we), .hand_row(hand_row), .hand_col(hand_col), .hand_obj(hand_obj),
        .board_we(board_we), .board_obj(board_obj),
        .pot_we(pot_we), .pot_obj(pot_obj),
        .grid(grid)
    );

    hand_action i_hand (
        .vsync(vsync), .reset(reset), .play(play), .player_state(player_state),
        .front_row(front_row), .front_col(front_col), .front_valid(front_valid), .grid(grid),
        .hand_we(hand_we), .hand_row(hand_row), .hand_col(hand_col), .hand_obj(hand_obj)
    );

    chop_board i_board (
        .vsync(vsync), .reset(reset), .play(play), .player_state(player_state),
        .front_row(front_row), .front_col(front_col), .front_valid(front_valid), .grid(grid),
        .board_we(board_we), .board_obj(board_obj), .chop_left(chop_left)
    );

    pot_cooker i_pot (
        .vsync(vsync), .reset(reset), .play(play), .grid(grid),
        .pot_we(pot_we), .pot_obj(pot_obj), .cook_left(cook_left)
    );

endmodule

`default_nettype wire

// File: verilog/kitchen_pkg.sv
`default_nettype none

package kitchen_pkg;

    localparam int GRID_ROWS = 8;
    localparam int GRID_COLS = 13;
    localparam int ROW_W = 3;
    localparam int COL_W = 4;
    localparam int PIXEL_W = 9;
    localparam int TIMER_W = 5;

    localparam logic [PIXEL_W-1:0] TILE_SIZE = 9'd32;
    localparam logic [PIXEL_W-1:0] SPRITE_CENTER = 9'd16;

    // frame counts
    localparam int CHOP_FRAMES = 6;
    localparam int COOK_FRAMES = 10;
    localparam int BURN_FRAMES = 5;

    localparam logic [ROW_W-1:0] CRATE_ROW_A = 3'd2;
    localparam logic [ROW_W-1:0] CRATE_ROW_B = 3'd3;
    localparam logic [COL_W-1:0] CRATE_COL = 4'd0;
    localparam logic [ROW_W-1:0] BOARD_ROW = 3'd7;
    localparam logic [COL_W-1:0] BOARD_COL = 4'd2;
    localparam logic [ROW_W-1:0] POT_ROW = 3'd0;
    localparam logic [COL_W-1:0] POT_COL = 4'd8;
    localparam logic [ROW_W-1:0] BOWL_ROW = 3'd6;
    localparam logic [COL_W-1:0] BOWL_COL = 4'd12;
    localparam logic [ROW_W-1:0] EXT_ROW = 3'd6;
    localparam logic [COL_W-1:0] EXT_COL = 4'd0;

    // 8 was a burning pot sprite and stays free
    typedef enum logic [3:0] {
        G_EMPTY = 4'd0, G_ONION_WHOLE = 4'd1, G_ONION_CHOPPED = 4'd2,
        G_BOWL_EMPTY = 4'd3, G_BOWL_FULL = 4'd4, G_POT_EMPTY = 4'd5,
        G_POT_RAW = 4'd6, G_POT_COOKED = 4'd7, G_FIRE = 4'd9, G_EXTINGUISHER = 4'd10
    } grid_obj_e;

    typedef enum logic [3:0] {
        P_NOTHING, P_CHOPPING, P_ONION_WHOLE, P_ONION_CHOPPED, P_POT_EMPTY, P_POT_RAW,
        P_POT_COOKED, P_BOWL_EMPTY, P_BOWL_FULL, P_EXT_OFF, P_EXT_ON
    } player_state_e;

    typedef enum logic [1:0] {LEFT, RIGHT, UP, DOWN} dir_e;

    typedef enum logic [1:0] {F_NONE, F_RAW, F_COOKED, F_FIRE} pot_state_e;

    typedef grid_obj_e [GRID_ROWS-1:0][GRID_COLS-1:0] grid_t; // row major

endpackage

`default_nettype wire

// File: verilog/object_grid.sv
`timescale 1ns/1ns
`default_nettype none

module object_grid (
    input  wire logic                          vsync,
    input  wire logic                          reset,
    input  wire logic                          hand_we,
    input  wire logic [kitchen_pkg::ROW_W-1:0] hand_row,
    input  wire logic [kitchen_pkg::COL_W-1:0] hand_col,
    input  wire kitchen_pkg::grid_obj_e        hand_obj,
    input  wire logic                          board_we,
    input  wire kitchen_pkg::grid_obj_e        board_obj,
    input  wire logic                          pot_we,
    input  wire kitchen_pkg::grid_obj_e        pot_obj,
    output kitchen_pkg::grid_t                 grid
);

    always_ff @(posedge vsync) begin
        if (reset) begin
            for (int r = 0; r < kitchen_pkg::GRID_ROWS; r++) begin
                for (int c = 0; c < kitchen_pkg::GRID_COLS; c++) begin
                    grid[r][c] <= kitchen_pkg::G_EMPTY;
                end
            end
            // start layout
            grid[kitchen_pkg::CRATE_ROW_A][kitchen_pkg::CRATE_COL] <= kitchen_pkg::G_ONION_WHOLE;
            grid[kitchen_pkg::CRATE_ROW_B][kitchen_pkg::CRATE_COL] <= kitchen_pkg::G_ONION_WHOLE;
            grid[kitchen_pkg::BOWL_ROW][kitchen_pkg::BOWL_COL] <= kitchen_pkg::G_BOWL_EMPTY;
            grid[kitchen_pkg::POT_ROW][kitchen_pkg::POT_COL] <= kitchen_pkg::G_POT_EMPTY;
            grid[kitchen_pkg::EXT_ROW][kitchen_pkg::EXT_COL] <= kitchen_pkg::G_EXTINGUISHER;
        end else begin
            // later writes win on a shared tile
            if (hand_we) begin
                grid[hand_row][hand_col] <= hand_obj;
            end
            if (board_we) begin
                grid[kitchen_pkg::BOARD_ROW][kitchen_pkg::BOARD_COL] <= board_obj;
            end
            if (pot_we) begin
                grid[kitchen_pkg::POT_ROW][kitchen_pkg::POT_COL] <= pot_obj;
            end
        end
    end

endmodule

`default_nettype wire

// File: verilog/player_locator.sv
`timescale 1ns/1ns
`default_nettype none

module player_locator (
    input  wire logic [kitchen_pkg::PIXEL_W-1:0] player_x,
    input  wire logic [kitchen_pkg::PIXEL_W-1:0] player_y,
    input  wire kitchen_pkg::dir_e               dir,
    output logic [kitchen_pkg::ROW_W-1:0]        row,
    output logic [kitchen_pkg::COL_W-1:0]        col,
    output logic [kitchen_pkg::ROW_W-1:0]        front_row,
    output logic [kitchen_pkg::COL_W-1:0]        front_col,
    output logic                                 front_valid
);

    logic [kitchen_pkg::PIXEL_W:0] center_x;
    logic [kitchen_pkg::PIXEL_W:0] center_y;
    logic [kitchen_pkg::PIXEL_W:0] tile_x;
    logic [kitchen_pkg::PIXEL_W:0] tile_y;
    logic                          on_grid;
    logic                          step_ok;

    // sprite position is its top left corner
    assign center_x = {1'b0, player_x} + kitchen_pkg::SPRITE_CENTER;
    assign center_y = {1'b0, player_y} + kitchen_pkg::SPRITE_CENTER;
    assign tile_x = center_x / kitchen_pkg::TILE_SIZE;
    assign tile_y = center_y / kitchen_pkg::TILE_SIZE;
    assign col = tile_x[kitchen_pkg::COL_W-1:0];
    assign row = tile_y[kitchen_pkg::ROW_W-1:0];
    assign on_grid = (tile_x < kitchen_pkg::GRID_COLS) && (tile_y < kitchen_pkg::GRID_ROWS);

    always_comb begin
        front_row = row;
        front_col = col;
        step_ok = 1'b0;
        case (dir)
            kitchen_pkg::LEFT: begin
                front_col = col - 1'b1;
                step_ok = (col != '0);
            end
            kitchen_pkg::RIGHT: begin
                front_col = col + 1'b1;
                step_ok = (col < kitchen_pkg::GRID_COLS - 1);
            end
            kitchen_pkg::UP: begin
                front_row = row - 1'b1;
                step_ok = (row != '0);
            end
            default: begin
                front_row = row + 1'b1;
                step_ok = (row < kitchen_pkg::GRID_ROWS - 1);
            end
        endcase
    end

    assign front_valid = on_grid && step_ok; // low at the grid edge

endmodule

`default_nettype wire

// File: verilog/pot_cooker.sv
`timescale 1ns/1ns
`default_nettype none

module pot_cooker (
    input  wire logic                       vsync,
    input  wire logic                       reset,
    input  wire logic                       play,
    input  wire kitchen_pkg::grid_t         grid,
    output logic                            pot_we,
    output kitchen_pkg::grid_obj_e          pot_obj,
    output logic [kitchen_pkg::TIMER_W-1:0] cook_left
);

    kitchen_pkg::pot_state_e          state;
    kitchen_pkg::grid_obj_e           pot_tile;
    logic                             cook_run;
    logic                             cook_restart;
    logic                             burn_run;
    logic                             burn_restart;
    logic [kitchen_pkg::TIMER_W-1:0]  burn_left;
    logic                             cook_done;
    logic                             burn_done;

    frame_timer #(.length(kitchen_pkg::COOK_FRAMES)) i_cook_timer (
        .vsync(vsync), .reset(reset), .run(cook_run), .restart(cook_restart),
        .time_left(cook_left)
    );

    frame_timer #(.length(kitchen_pkg::BURN_FRAMES)) i_burn_timer (
        .vsync(vsync), .reset(reset), .run(burn_run), .restart(burn_restart),
        .time_left(burn_left)
    );

    assign pot_tile = grid[kitchen_pkg::POT_ROW][kitchen_pkg::POT_COL];
    assign cook_done = (state == kitchen_pkg::F_RAW) && (pot_tile == kitchen_pkg::G_POT_RAW) &&
                       (cook_left == '0);
    assign burn_done = (state == kitchen_pkg::F_COOKED) &&
                       (pot_tile == kitchen_pkg::G_POT_COOKED) && (burn_left == '0);

    assign pot_we = play && (cook_done || burn_done);
    assign pot_obj = cook_done ? kitchen_pkg::G_POT_COOKED : kitchen_pkg::G_FIRE;

    // each phase starts once its object shows on the pot tile
    always_ff @(posedge vsync) begin
        if (reset) begin
            state <= kitchen_pkg::F_NONE;
            cook_run <= 1'b0;
            cook_restart <= 1'b1;
            burn_run <= 1'b0;
            burn_restart <= 1'b1;
        end else if (!play) begin
            cook_run <= 1'b0;
            burn_run <= 1'b0;
        end else begin
            cook_run <= 1'b0;
            cook_restart <= 1'b1;
            burn_run <= 1'b0;
            burn_restart <= 1'b1;
            case (state)
                kitchen_pkg::F_NONE: begin
                    if (pot_tile == kitchen_pkg::G_POT_RAW) begin
                        state <= kitchen_pkg::F_RAW;
                    end
                end
                kitchen_pkg::F_RAW: begin
                    if (pot_tile == kitchen_pkg::G_POT_RAW) begin
                        cook_run <= 1'b1;
                        cook_restart <= 1'b0;
                    end else if (pot_tile == kitchen_pkg::G_POT_COOKED) begin
                        state <= kitchen_pkg::F_COOKED;
                    end else begin
                        state <= kitchen_pkg::F_NONE; // pot taken away
                    end
                end
                kitchen_pkg::F_COOKED: begin
                    if (pot_tile == kitchen_pkg::G_POT_COOKED) begin
                        burn_run <= 1'b1;
                        burn_restart <= 1'b0;
                    end else if (pot_tile == kitchen_pkg::G_FIRE) begin
                        state <= kitchen_pkg::F_FIRE;
                    end else begin
                        state <= kitchen_pkg::F_NONE;
                    end
                end
                default: begin
                    if (pot_tile != kitchen_pkg::G_FIRE) begin
                        state <= kitchen_pkg::F_NONE; // put out
                    end
                end
            endcase
        end
    end

endmodule

`default_nettype wire
